// ==== verif/ldst_vectors.txt ====
# op dir order addr wdata | port exp_addr exp_mask chk, all hex
# op 0 request, 1 sysinfo (addr is IO start), 2 lock stall (wdata 1 hold, 0 release); port 2 = core_err
0 0 2 f0000000 11223344 0 f0000000 f 0
0 0 0 00000100 000000aa 0 00000100 1 0
0 0 0 00000101 000000bb 0 00000101 2 0
0 0 0 00000102 000000cc 0 00000102 4 0
0 0 0 00000103 000000dd 0 00000103 8 0
0 0 1 00000104 0000beef 0 00000104 3 0
0 0 1 00000106 0000cafe 0 00000106 c 0
0 0 2 00000108 deadbeef 0 00000108 f 0
0 1 0 00000102 00000000 0 00000102 4 1
0 1 1 00000106 00000000 0 00000106 c 1
0 1 2 00000104 00000000 0 00000104 f 1
0 1 2 00000108 00000000 0 00000108 f 1
0 1 0 00000035 00000000 0 00000035 2 1
0 0 1 00000101 00000000 2 00000000 0 0
0 1 2 00000102 00000000 2 00000000 0 0
0 0 3 00000100 00000000 2 00000000 0 0
1 0 0 80000000 00000000 0 00000000 0 0
0 0 2 80000010 12345678 1 00000010 f 0
0 1 1 80000022 00000000 1 00000022 c 1
0 1 0 80000013 00000000 1 00000013 8 1
0 1 0 7ffffffd 00000000 0 7ffffffd 2 1
2 0 0 00000000 00000001 0 00000000 0 0
0 0 2 00000200 a0a0a0a0 0 00000200 f 0
0 0 2 00000204 b1b1b1b1 0 00000204 f 0
0 0 2 00000208 c2c2c2c2 0 00000208 f 0
0 0 2 0000020c d3d3d3d3 0 0000020c f 0
2 0 0 00000000 00000000 0 00000000 0 0
0 1 2 00000204 00000000 0 00000204 f 1
0 1 1 0000020e 00000000 0 0000020e c 1

// ==== mist_ldst.f ====
+incdir+source
source/mem_bus_pkg.sv
source/ldst_types_pkg.sv
source/ldst_issue.sv
source/ldst_req_fifo.sv
source/ldst_router.sv
source/ldst_unit.sv
verif/tb_ldst_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_ldst_unit -f mist_ldst.f -o sim_ldst

./obj_dir/sim_ldst > sim.log 2>&1
cat sim.log

if grep -q "sim passed" sim.log; then
	exit 0
else
	exit 1
fi

// ==== verif/tb_ldst_unit.sv ====
`timescale 1ns/1ps

module tb_ldst_unit;

	// Expected port strobe, one per accepted request
	typedef struct packed {
		logic [1:0]  port;
		logic        rw;
		logic [1:0]  order;
		logic [31:0] addr;
		logic [3:0]  mask;
		logic [31:0] data;
		logic        chk;
		int          idx;
	} exp_port_t;

	// Expected read result and the vector it came from
	typedef struct packed {
		logic [31:0] value;
		logic        chk;
		int          idx;
	} exp_rd_t;

	logic iCLOCK;
	logic rst;
	logic core_req;
	ldst_types_pkg::dir_e   core_dir;
	ldst_types_pkg::order_e core_order;
	ldst_types_pkg::addr_t  core_addr;
	ldst_types_pkg::word_t  core_data;
	logic core_busy;
	logic core_err;
	logic core_rd_valid;
	ldst_types_pkg::word_t  core_rd_data;
	logic sysinfo_valid;
	ldst_types_pkg::addr_t  sysinfo_iosr;
	logic data_req;
	logic data_lock;
	mem_bus_pkg::port_req_t data_out;
	logic data_valid;
	mem_bus_pkg::bus_t      data_rdata;
	logic io_req;
	logic io_busy;
	mem_bus_pkg::port_req_t io_out;
	logic io_valid;
	ldst_types_pkg::word_t  io_rdata;

	// Vector table
	logic [31:0] v_op [64];
	logic [31:0] v_dir [64];
	logic [31:0] v_ord [64];
	logic [31:0] v_addr [64];
	logic [31:0] v_wdata [64];
	logic [31:0] v_port [64];
	logic [31:0] v_eaddr [64];
	logic [31:0] v_emask [64];
	logic [31:0] v_chk [64];
	int n_vec = 0;

	exp_port_t exp_q[$];
	exp_rd_t   rd_q[$];
	logic [63:0] mem [256];
	integer seed = 32'h8856d4a2;
	int errors = 0;
	int checks = 0;
	int io_writes = 0;
	int data_cnt = 0;
	int io_cnt = 0;
	logic [31:0] data_rd_addr;
	logic [31:0] io_rd_addr;
	logic force_lock = 1'b0;
	logic saw_busy = 1'b0;

	ldst_unit u_dut (.*);

	initial begin
		iCLOCK = 1'b0;
		forever #2 iCLOCK = ~iCLOCK;
	end

	// IO read data, a fixed function of the rebased address
	function automatic logic [31:0] io_value(input logic [31:0] a);
		return {a[15:0] ^ 16'h9e37, ~a[15:0]};
	endfunction

	// Half by bit 2, byte offset, then zero-extend to the access size
	function automatic logic [31:0] pick(input logic [63:0] w, input logic [31:0] a,
			input logic [1:0] ord);
		logic [31:0] half;
		half = a[2] ? w[63:32] : w[31:0];
		half = half >> (8 * a[1:0]);
		if (ord == 2'd0)
			return half & 32'h0000_00ff;
		else if (ord == 2'd1)
			return half & 32'h0000_ffff;
		return half;
	endfunction

	task automatic check_eq(input string name, input logic [63:0] expv, input logic [63:0] act);
		checks++;
		assert (expv === act) else begin
			errors++;
			$display("FAILED %s expected %h actual %h", name, expv, act);
		end
	endtask

	// Compare one port strobe with the head of the scoreboard
	task automatic take_strobe(input logic [1:0] port, input mem_bus_pkg::port_req_t r);
		exp_port_t e;
		logic [63:0] lanes;
		assert (exp_q.size() != 0) else begin
			errors++;
			$display("Port strobe seen while no request was pending");
			return;
		end
		e = exp_q.pop_front();
		check_eq($sformatf("vec%0d port", e.idx), e.port, port);
		check_eq($sformatf("vec%0d rw", e.idx), e.rw, r.rw);
		check_eq($sformatf("vec%0d order", e.idx), e.order, r.order);
		check_eq($sformatf("vec%0d addr", e.idx), e.addr, r.addr);
		check_eq($sformatf("vec%0d mask", e.idx), e.mask, r.mask);
		if (!e.rw) begin
			check_eq($sformatf("vec%0d wdata", e.idx), e.data, r.data);
			if (port == 2'd1) begin
				io_writes++;
			end else begin
				// Masked write into the addressed half
				for (int b = 0; b < 4; b++) begin
					if (r.mask[b]) begin
						lanes = mem[r.addr[10:3]];
						lanes[(r.addr[2] * 32) + b * 8 +: 8] = r.data[b * 8 +: 8];
						mem[r.addr[10:3]] = lanes;
					end
				end
			end
		end else if (port == 2'd1) begin
			rd_q.push_back(exp_rd_t'{pick({32'h0, io_value(e.addr)},
				{e.addr[31:3], 1'b0, e.addr[1:0]}, e.order), e.chk, e.idx});
			io_rd_addr = r.addr;
			io_cnt = 1;
		end else begin
			rd_q.push_back(exp_rd_t'{pick(mem[e.addr[10:3]], e.addr, e.order), e.chk, e.idx});
			data_rd_addr = r.addr;
			data_cnt = 1 + ($unsigned($random(seed)) % 3);
		end
	endtask

	// Memory and IO models, sampled and driven 1 ns after the edge
	always begin
		exp_rd_t r;
		@(posedge iCLOCK);
		#1;
		data_valid = 1'b0;
		io_valid = 1'b0;
		if (core_busy)
			saw_busy = 1'b1;
		if (data_cnt > 0) begin
			data_cnt--;
			if (data_cnt == 0) begin
				data_valid = 1'b1;
				data_rdata = mem[data_rd_addr[10:3]];
			end
		end
		if (io_cnt > 0) begin
			io_cnt = 0;
			io_valid = 1'b1;
			io_rdata = io_value(io_rd_addr);
		end
		if (!rst && data_req)
			take_strobe(2'd0, data_out);
		if (!rst && io_req)
			take_strobe(2'd1, io_out);
		if (!rst && core_rd_valid) begin
			assert (rd_q.size() != 0) else begin
				errors++;
				$display("Read data returned with no read pending");
			end
			if (rd_q.size() != 0) begin
				r = rd_q.pop_front();
				if (r.chk)
					check_eq($sformatf("vec%0d rdata", r.idx), r.value, core_rd_data);
			end
		end
		data_lock = force_lock || (($random(seed) & 3) == 0);
	end

	task automatic load_vectors();
		int fd;
		int n;
		string line;
		fd = $fopen("verif/ldst_vectors.txt", "r");
		assert (fd != 0) else begin
			errors++;
			$display("Cannot open the vector file");
			return;
		end
		while (!$feof(fd) && n_vec < 64) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 1 && line[0] != "#") begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", v_op[n_vec], v_dir[n_vec],
					v_ord[n_vec], v_addr[n_vec], v_wdata[n_vec], v_port[n_vec],
					v_eaddr[n_vec], v_emask[n_vec], v_chk[n_vec]);
				if (n == 9)
					n_vec++;
			end
		end
		$fclose(fd);
	endtask

	// Let every queued request and read finish
	task automatic drain();
		while (exp_q.size() != 0 || rd_q.size() != 0) begin
			@(posedge iCLOCK);
			#1;
		end
	endtask

	task automatic run_vector(input int i);
		if (v_op[i] == 1) begin
			drain();
			sysinfo_valid = 1'b1;
			sysinfo_iosr = v_addr[i];
			@(posedge iCLOCK);
			#1;
			sysinfo_valid = 1'b0;
		end else if (v_op[i] == 2) begin
			if (v_wdata[i][0]) begin
				saw_busy = 1'b0;
				force_lock = 1'b1;
			end else begin
				repeat (4) @(posedge iCLOCK);
				#1;
				checks++;
				assert (saw_busy) else begin
					errors++;
					$display("core_busy never rose during the data_lock stall, vec%0d", i);
				end
				force_lock = 1'b0;
			end
		end else begin
			while (core_busy) begin
				@(posedge iCLOCK);
				#1;
			end
			if (v_port[i] != 2)
				exp_q.push_back(exp_port_t'{v_port[i][1:0], v_dir[i][0], v_ord[i][1:0],
					v_eaddr[i], v_emask[i][3:0], v_wdata[i] << (8 * v_addr[i][1:0]),
					v_chk[i][0], i});
			core_req = 1'b1;
			core_dir = ldst_types_pkg::dir_e'(v_dir[i][0]);
			core_order = ldst_types_pkg::order_e'(v_ord[i][1:0]);
			core_addr = v_addr[i];
			core_data = v_wdata[i];
			@(posedge iCLOCK);
			#1;
			core_req = 1'b0;
			check_eq($sformatf("vec%0d core_err", i), v_port[i] == 2, core_err);
		end
	endtask

	// Watchdog scaled by the vector count
	initial begin
		wait (n_vec > 0 && rst === 1'b0);
		repeat (n_vec * 40) @(posedge iCLOCK);
		$display("Timeout, the vector run did not finish in time");
		$display("sim failed");
		$finish;
	end

	initial begin
		rst = 1'b1;
		core_req = 1'b0;
		core_dir = ldst_types_pkg::DIR_WRITE;
		core_order = ldst_types_pkg::ORDER_BYTE;
		core_addr = '0;
		core_data = '0;
		sysinfo_valid = 1'b0;
		sysinfo_iosr = '0;
		data_lock = 1'b0;
		data_valid = 1'b0;
		data_rdata = '0;
		io_busy = 1'b0;
		io_valid = 1'b0;
		io_rdata = '0;
		// Fill pattern from the word index, one half per address
		for (int i = 0; i < 256; i++)
			mem[i] = {32'(i * 8 + 4) ^ 32'hc3a5_0000, 32'(i * 8) ^ 32'h5a3c_0000};
		load_vectors();
		repeat (3) @(posedge iCLOCK);
		#1;
		rst = 1'b0;
		for (int i = 0; i < n_vec; i++)
			run_vector(i);
		drain();
		repeat (5) @(posedge iCLOCK);
		$display("errors %0d, checks %0d, io writes %0d", errors, checks, io_writes);
		if (errors == 0 && n_vec > 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== source/ldst_unit.sv ====
`timescale 1ns/1ps

`include "mist_ldst_defines.svh"

module ldst_unit (
	input  logic                   iCLOCK,
	input  logic                   rst,
	// Core side
	input  logic                   core_req,
	input  ldst_types_pkg::dir_e   core_dir,
	input  ldst_types_pkg::order_e core_order,
	input  ldst_types_pkg::addr_t  core_addr,
	input  ldst_types_pkg::word_t  core_data,
	output logic                   core_busy,
	output logic                   core_err,
	output logic                   core_rd_valid,
	output ldst_types_pkg::word_t  core_rd_data,
	// System information
	input  logic                   sysinfo_valid,
	input  ldst_types_pkg::addr_t  sysinfo_iosr,
	// Data memory port
	output logic                   data_req,
	input  logic                   data_lock,
	output mem_bus_pkg::port_req_t data_out,
	input  logic                   data_valid,
	input  mem_bus_pkg::bus_t      data_rdata,
	// IO port
	output logic                   io_req,
	input  logic                   io_busy,
	output mem_bus_pkg::port_req_t io_out,
	input  logic                   io_valid,
	input  ldst_types_pkg::word_t  io_rdata
);

	logic                      push;
	ldst_types_pkg::ldst_req_t push_entry;
	logic                      not_empty;
	ldst_types_pkg::ldst_req_t head;
	logic                      pop;

	// Check and pack
	ldst_issue u_issue (
		.iCLOCK     (iCLOCK),
		.rst        (rst),
		.core_req   (core_req),
		.core_dir   (core_dir),
		.core_order (core_order),
		.core_addr  (core_addr),
		.core_data  (core_data),
		.push       (push),
		.push_entry (push_entry),
		.core_err   (core_err)
	);

	// Request queue, its nearly-full flag throttles the core
	ldst_req_fifo #(
		.DEPTH (`MIST_FIFO_DEPTH)
	) u_fifo (
		.iCLOCK     (iCLOCK),
		.rst        (rst),
		.push       (push),
		.push_entry (push_entry),
		.pop        (pop),
		.not_empty  (not_empty),
		.head       (head),
		.busy       (core_busy)
	);

	// Data or IO steering
	ldst_router u_router (
		.iCLOCK        (iCLOCK),
		.rst           (rst),
		.sysinfo_valid (sysinfo_valid),
		.sysinfo_iosr  (sysinfo_iosr),
		.not_empty     (not_empty),
		.head          (head),
		.data_lock     (data_lock),
		.data_valid    (data_valid),
		.data_rdata    (data_rdata),
		.io_busy       (io_busy),
		.io_valid      (io_valid),
		.io_rdata      (io_rdata),
		.pop           (pop),
		.data_req      (data_req),
		.data_out      (data_out),
		.io_req        (io_req),
		.io_out        (io_out),
		.core_rd_valid (core_rd_valid),
		.core_rd_data  (core_rd_data)
	);

endmodule

// ==== source/ldst_router.sv ====
`timescale 1ns/1ps

`include "mist_ldst_defines.svh"

module ldst_router (
	input  logic                      iCLOCK,
	input  logic                      rst,
	input  logic                      sysinfo_valid,
	input  ldst_types_pkg::addr_t     sysinfo_iosr,
	input  logic                      not_empty,
	input  ldst_types_pkg::ldst_req_t head,
	input  logic                      data_lock,
	input  logic                      data_valid,
	input  mem_bus_pkg::bus_t         data_rdata,
	input  logic                      io_busy,
	input  logic                      io_valid,
	input  ldst_types_pkg::word_t     io_rdata,
	output logic                      pop,
	output logic                      data_req,
	output mem_bus_pkg::port_req_t    data_out,
	output logic                      io_req,
	output mem_bus_pkg::port_req_t    io_out,
	output logic                      core_rd_valid,
	output ldst_types_pkg::word_t     core_rd_data
);

	ldst_types_pkg::route_state_e state;
	ldst_types_pkg::addr_t        io_start;
	logic                         io_start_set;
	mem_bus_pkg::port_req_t       cur_req;
	logic                         cur_io;

	logic                  to_io;
	logic                  head_lock;
	logic                  cur_lock;
	logic                  rd_done;
	ldst_types_pkg::word_t rd_word;
	ldst_types_pkg::word_t rd_shift;
	ldst_types_pkg::word_t rd_aligned;

	// Target of the head entry, IO only once system info has arrived
	assign to_io     = io_start_set && (head.addr >= io_start);
	assign head_lock = to_io ? io_busy : data_lock;
	assign cur_lock  = cur_io ? io_busy : data_lock;
	assign pop       = (state == ldst_types_pkg::ST_IDLE) && not_empty;
	assign rd_done   = cur_io ? io_valid : data_valid;

	// Read lane select, upper half of the 64-bit word on address bit 2
	assign rd_word = cur_io ? io_rdata :
		(cur_req.addr[2] ? data_rdata[2*`MIST_DATA_W-1:`MIST_DATA_W]
			: data_rdata[`MIST_DATA_W-1:0]);
	assign rd_shift = rd_word >> {cur_req.addr[1:0], 3'b000};

	// Zero-extend to the access size
	always_comb begin
		case (ldst_types_pkg::order_e'(cur_req.order))
			ldst_types_pkg::ORDER_BYTE:
				rd_aligned = {{(`MIST_DATA_W-8){1'b0}}, rd_shift[7:0]};
			ldst_types_pkg::ORDER_HALF:
				rd_aligned = {{(`MIST_DATA_W-16){1'b0}}, rd_shift[15:0]};
			default:
				rd_aligned = rd_shift;
		endcase
	end

	// FSM and strobes
	always_ff @(posedge iCLOCK) begin
		if (rst) begin
			state         <= ldst_types_pkg::ST_IDLE;
			data_req      <= 1'b0;
			io_req        <= 1'b0;
			core_rd_valid <= 1'b0;
			io_start      <= `MIST_IO_START_RST;
			io_start_set  <= 1'b0;
		end else begin
			data_req      <= 1'b0;
			io_req        <= 1'b0;
			core_rd_valid <= 1'b0;
			if (sysinfo_valid) begin
				io_start     <= sysinfo_iosr;
				io_start_set <= 1'b1;
			end
			case (state)
				ldst_types_pkg::ST_IDLE: begin
					if (pop) begin
						// Port free already, strobe on the next cycle
						if (!head_lock) begin
							data_req <= !to_io;
							io_req   <= to_io;
							state    <= (head.dir == ldst_types_pkg::DIR_READ)
								? ldst_types_pkg::ST_WAIT_RD : ldst_types_pkg::ST_IDLE;
						end else begin
							state <= ldst_types_pkg::ST_ISSUE;
						end
					end
				end
				ldst_types_pkg::ST_ISSUE: begin
					// Hold until the chosen port drops its lock
					if (!cur_lock) begin
						data_req <= !cur_io;
						io_req   <= cur_io;
						state    <= cur_req.rw ? ldst_types_pkg::ST_WAIT_RD
							: ldst_types_pkg::ST_IDLE;
					end
				end
				ldst_types_pkg::ST_WAIT_RD: begin
					if (rd_done) begin
						core_rd_valid <= 1'b1;
						state         <= ldst_types_pkg::ST_IDLE;
					end
				end
				default: state <= ldst_types_pkg::ST_IDLE;
			endcase
		end
	end

	// Popped entry, IO address rebased to the IO start
	always_ff @(posedge iCLOCK) begin
		if (pop) begin
			cur_req.rw    <= (head.dir == ldst_types_pkg::DIR_READ);
			cur_req.order <= head.order;
			cur_req.addr  <= to_io ? head.addr - io_start : head.addr;
			cur_req.data  <= head.data;
			cur_req.mask  <= head.mask;
			cur_io        <= to_io;
		end
		if (state == ldst_types_pkg::ST_WAIT_RD && rd_done) begin
			core_rd_data <= rd_aligned;
		end
	end

	// Both ports see the same request, only the strobe differs
	assign data_out = cur_req;
	assign io_out   = cur_req;

	// Ports only answer the one outstanding read
	a_valid_in_wait: assert property (@(posedge iCLOCK) disable iff (rst)
		(data_valid || io_valid) |-> (state == ldst_types_pkg::ST_WAIT_RD));

	// Strobe only after the port's lock was seen low
	a_data_lock_low: assert property (@(posedge iCLOCK) disable iff (rst)
		data_req |-> !$past(data_lock));

	a_io_busy_low: assert property (@(posedge iCLOCK) disable iff (rst)
		io_req |-> !$past(io_busy));

endmodule

// ==== source/ldst_req_fifo.sv ====
`timescale 1ns/1ps

`include "mist_ldst_defines.svh"

module ldst_req_fifo #(
	parameter int DEPTH = `MIST_FIFO_DEPTH
) (
	input  logic                      iCLOCK,
	input  logic                      rst,
	input  logic                      push,
	input  ldst_types_pkg::ldst_req_t push_entry,
	input  logic                      pop,
	output logic                      not_empty,
	output ldst_types_pkg::ldst_req_t head,
	output logic                      busy
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	ldst_types_pkg::ldst_req_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// Storage
	always_ff @(posedge iCLOCK) begin
		if (push) begin
			mem[wr_ptr] <= push_entry;
		end
	end

	// Pointers wrap at DEPTH, which need not be a power of two
	always_ff @(posedge iCLOCK) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
		end
	end

	// Fill level
	always_ff @(posedge iCLOCK) begin
		if (rst) begin
			count <= '0;
		end else begin
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign not_empty = (count != '0);
	assign head      = mem[rd_ptr];

	// One slot kept back for the request still inside the issue stage
	assign busy = (count >= CNT_W'(DEPTH - 1));

	// Producer honours busy, so the queue never overflows
	a_no_push_full: assert property (@(posedge iCLOCK) disable iff (rst)
		push |-> (count != CNT_W'(DEPTH)) || pop);

	a_no_pop_empty: assert property (@(posedge iCLOCK) disable iff (rst)
		pop |-> not_empty);

endmodule

// ==== source/ldst_issue.sv ====
`timescale 1ns/1ps

module ldst_issue (
	input  logic                      iCLOCK,
	input  logic                      rst,
	input  logic                      core_req,
	input  ldst_types_pkg::dir_e      core_dir,
	input  ldst_types_pkg::order_e    core_order,
	input  ldst_types_pkg::addr_t     core_addr,
	input  ldst_types_pkg::word_t     core_data,
	output logic                      push,
	output ldst_types_pkg::ldst_req_t push_entry,
	output logic                      core_err
);

	logic                  bad_req;
	mem_bus_pkg::mask_t    base_mask;
	mem_bus_pkg::mask_t    lane_mask;
	ldst_types_pkg::word_t lane_data;

	// Alignment and order check
	always_comb begin
		case (core_order)
			ldst_types_pkg::ORDER_BYTE: bad_req = 1'b0;
			ldst_types_pkg::ORDER_HALF: bad_req = core_addr[0];
			ldst_types_pkg::ORDER_WORD: bad_req = |core_addr[1:0];
			// Order none never goes out
			default: bad_req = 1'b1;
		endcase
	end

	// Lanes touched at offset zero
	always_comb begin
		case (core_order)
			ldst_types_pkg::ORDER_BYTE: base_mask = 4'b0001;
			ldst_types_pkg::ORDER_HALF: base_mask = 4'b0011;
			default: base_mask = 4'b1111;
		endcase
	end

	// Move mask and write data up to the byte offset
	assign lane_mask = base_mask << core_addr[1:0];
	assign lane_data = core_data << {core_addr[1:0], 3'b000};

	// Strobes
	always_ff @(posedge iCLOCK) begin
		if (rst) begin
			push     <= 1'b0;
			core_err <= 1'b0;
		end else begin
			push     <= core_req && !bad_req;
			core_err <= core_req && bad_req;
		end
	end

	// Entry only loads for a good request
	always_ff @(posedge iCLOCK) begin
		if (core_req && !bad_req) begin
			push_entry.dir   <= core_dir;
			push_entry.order <= core_order;
			push_entry.addr  <= core_addr;
			push_entry.data  <= lane_data;
			push_entry.mask  <= lane_mask;
		end
	end

	// Core must not replay a rejected request straight after the error
	a_no_replay: assert property (@(posedge iCLOCK) disable iff (rst)
		core_err |=> !(core_req && core_addr == $past(core_addr, 2)
			&& core_order == $past(core_order, 2)
			&& core_dir == $past(core_dir, 2)));

endmodule

// ==== source/ldst_types_pkg.sv ====
package ldst_types_pkg;

	`include "mist_ldst_defines.svh"

	typedef logic [`MIST_ADDR_W-1:0] addr_t;
	typedef logic [`MIST_DATA_W-1:0] word_t;

	// Access size, same codes as the core pipeline
	typedef enum logic [1:0] {
		ORDER_BYTE = 2'b00,
		ORDER_HALF = 2'b01,
		ORDER_WORD = 2'b10,
		ORDER_NONE = 2'b11
	} order_e;

	typedef enum logic {
		DIR_WRITE = 1'b0,
		DIR_READ  = 1'b1
	} dir_e;

	// Queue entry, data already moved into its byte lanes
	typedef struct packed {
		dir_e               dir;
		order_e             order;
		addr_t              addr;
		word_t              data;
		mem_bus_pkg::mask_t mask;
	} ldst_req_t;

	// Router FSM
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_WAIT_RD
	} route_state_e;

endpackage

// ==== source/mem_bus_pkg.sv ====
package mem_bus_pkg;

	`include "mist_ldst_defines.svh"

	// Byte lane enables, bit 0 is the lowest byte
	typedef logic [`MIST_MASK_W-1:0] mask_t;

	// Full data memory read word
	typedef logic [`MIST_BUS_W-1:0] bus_t;

	// Request as seen on the data and IO ports
	// rw follows the IO port: 0 write, 1 read
	// order keeps the core encoding (byte, half, word)
	typedef struct packed {
		logic                    rw;
		logic [1:0]              order;
		logic [`MIST_ADDR_W-1:0] addr;
		logic [`MIST_DATA_W-1:0] data;
		mask_t                   mask;
	} port_req_t;

endpackage

// ==== source/mist_ldst_defines.svh ====
`ifndef MIST_LDST_DEFINES_SVH
`define MIST_LDST_DEFINES_SVH

// Byte address width
`define MIST_ADDR_W 32

// Core data word width
`define MIST_DATA_W 32

// Data memory read bus, two core words wide
`define MIST_BUS_W 64

// One enable bit per byte lane of a core word
`define MIST_MASK_W (`MIST_DATA_W / 8)

// Request queue entries
`define MIST_FIFO_DEPTH 4

// IO start after reset, top of the address space
`define MIST_IO_START_RST 32'hFFFF_FFFF

`endif
